// ==== hdl/fetch_pkg.sv ====
`include "fetch_defs.svh"

package fetch_pkg;

  // upstream payload
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] pc;
  } fetch_req_t;

  // downstream payload
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] pc;
    logic [`FETCH_DATA_W-1:0] inst;
  } fetch_rsp_t;

  // master side of the APB read bus
  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic [`FETCH_ADDR_W-1:0] paddr;
  } apb_req_t;

  // slave side
  typedef struct packed {
    logic                     pready;
    logic [`FETCH_DATA_W-1:0] prdata;
  } apb_rsp_t;

  // one complete cache line from the refill controller
  typedef struct packed {
    logic [`ICACHE_IDX_W-1:0]                          idx;
    logic [`ICACHE_TAG_W-1:0]                          tag;
    logic [`ICACHE_LINE_WORDS-1:0][`FETCH_DATA_W-1:0] data;
  } line_fill_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_LOOKUP,
    FETCH_MISS,
    FETCH_HOLD
  } fetch_state_e;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_SETUP,
    REFILL_ACCESS,
    REFILL_WRITE
  } refill_state_e;

  // which word of the line the current APB beat reads
  typedef enum logic {
    BEAT_FIRST,
    BEAT_SECOND
  } refill_beat_e;

endpackage

// ==== hdl/fetch_stage.sv ====
`include "fetch_defs.svh"

module fetch_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     up_valid_i,
  output logic                     up_ready_o,
  input  fetch_pkg::fetch_req_t    up_req_i,
  output logic                     dn_valid_o,
  input  logic                     dn_ready_i,
  output fetch_pkg::fetch_rsp_t    dn_rsp_o,
  output logic [`FETCH_ADDR_W-1:0] lookup_pc_o,
  input  logic                     hit_i,
  input  logic [`FETCH_DATA_W-1:0] hit_word_i,
  output logic                     flush_o,
  output logic                     miss_req_o,
  output logic [`FETCH_ADDR_W-1:0] miss_addr_o,
  input  logic                     fill_done_i
);

  import fetch_pkg::*;

  fetch_state_e             state_q;
  logic [`FETCH_ADDR_W-1:0] pc_q;
  fetch_rsp_t               rsp_q;

  logic up_fire;
  logic dn_fire;

  assign up_fire = up_valid_i && up_ready_o;
  assign dn_fire = dn_valid_o && dn_ready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= FETCH_IDLE;
    end
    else
    begin
      case (state_q)
        FETCH_IDLE:
          if (up_valid_i)
          begin
            state_q <= FETCH_LOOKUP;
          end
        FETCH_LOOKUP:
          if (hit_i)
          begin
            state_q <= FETCH_HOLD;
          end
          else
          begin
            state_q <= FETCH_MISS;
          end
        // retry once the line is in
        FETCH_MISS:
          if (fill_done_i)
          begin
            state_q <= FETCH_LOOKUP;
          end
        FETCH_HOLD:
          if (dn_ready_i)
          begin
            state_q <= FETCH_IDLE;
          end
        default:
          state_q <= FETCH_IDLE;
      endcase
    end
  end

  // accepted pc and the response it produces
  always_ff @(posedge clk)
  begin
    if (up_fire)
    begin
      pc_q <= up_req_i.pc;
    end
    if (state_q == FETCH_LOOKUP && hit_i)
    begin
      rsp_q.pc   <= pc_q;
      rsp_q.inst <= hit_word_i;
    end
  end

  assign up_ready_o  = (state_q == FETCH_IDLE);
  assign dn_valid_o  = (state_q == FETCH_HOLD);
  assign dn_rsp_o    = rsp_q;
  assign lookup_pc_o = pc_q;

  // refill request for the aligned line
  assign miss_req_o  = (state_q == FETCH_MISS);
  assign miss_addr_o = {pc_q[`FETCH_ADDR_W-1:`ICACHE_IDX_LSB], {`ICACHE_IDX_LSB{1'b0}}};

  // fence.i clears the cache as it leaves for decode
  assign flush_o = dn_fire && (rsp_q.inst == `FENCE_I_INST);

  a_dn_stable: assert property (
    @(posedge clk) disable iff (rst)
    dn_valid_o && !dn_ready_i |=> dn_valid_o && $stable(dn_rsp_o)
  );

  // request and its address held until the line is written
  a_miss_held: assert property (
    @(posedge clk) disable iff (rst)
    miss_req_o && !fill_done_i |=> miss_req_o && $stable(miss_addr_o)
  );

endmodule

// ==== hdl/fetch_top.sv ====
`include "fetch_defs.svh"

module fetch_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  up_valid_i,
  output logic                  up_ready_o,
  input  fetch_pkg::fetch_req_t up_req_i,
  output logic                  dn_valid_o,
  input  logic                  dn_ready_i,
  output fetch_pkg::fetch_rsp_t dn_rsp_o,
  output fetch_pkg::apb_req_t   apb_req_o,
  input  fetch_pkg::apb_rsp_t   apb_rsp_i
);

  import fetch_pkg::*;

  // stage to array
  logic [`FETCH_ADDR_W-1:0] lookup_pc;
  logic                     hit;
  logic [`FETCH_DATA_W-1:0] hit_word;
  logic                     flush;

  // stage to refill controller
  logic                     miss_req;
  logic [`FETCH_ADDR_W-1:0] miss_addr;
  logic                     fill_done;
  line_fill_t               fill;

  fetch_stage i_stage (
    .clk         (clk),
    .rst         (rst),
    .up_valid_i  (up_valid_i),
    .up_ready_o  (up_ready_o),
    .up_req_i    (up_req_i),
    .dn_valid_o  (dn_valid_o),
    .dn_ready_i  (dn_ready_i),
    .dn_rsp_o    (dn_rsp_o),
    .lookup_pc_o (lookup_pc),
    .hit_i       (hit),
    .hit_word_i  (hit_word),
    .flush_o     (flush),
    .miss_req_o  (miss_req),
    .miss_addr_o (miss_addr),
    .fill_done_i (fill_done)
  );

  icache_array i_array (
    .clk         (clk),
    .rst         (rst),
    .lookup_pc_i (lookup_pc),
    .hit_o       (hit),
    .hit_word_o  (hit_word),
    .fill_i      (fill),
    .fill_we_i   (fill_done),
    .flush_i     (flush)
  );

  icache_refill i_refill (
    .clk         (clk),
    .rst         (rst),
    .miss_req_i  (miss_req),
    .miss_addr_i (miss_addr),
    .fill_done_o (fill_done),
    .fill_o      (fill),
    .apb_req_o   (apb_req_o),
    .apb_rsp_i   (apb_rsp_i)
  );

endmodule

// ==== hdl/icache_array.sv ====
`include "fetch_defs.svh"

module icache_array (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`FETCH_ADDR_W-1:0] lookup_pc_i,
  output logic                     hit_o,
  output logic [`FETCH_DATA_W-1:0] hit_word_o,
  input  fetch_pkg::line_fill_t    fill_i,
  input  logic                     fill_we_i,
  input  logic                     flush_i
);

  // line storage, tags and valid bits
  logic [`ICACHE_LINE_WORDS-1:0][`FETCH_DATA_W-1:0] data_q [`ICACHE_SETS];
  logic [`ICACHE_TAG_W-1:0]                          tag_q  [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0]                           valid_q;

  // lookup fields
  logic [`ICACHE_IDX_W-1:0] lu_idx;
  logic [`ICACHE_TAG_W-1:0] lu_tag;
  logic [`ICACHE_OFS_W-1:0] lu_ofs;

  assign lu_ofs = lookup_pc_i[`ICACHE_IDX_LSB-1:`ICACHE_OFS_LSB];
  assign lu_idx = lookup_pc_i[`ICACHE_TAG_LSB-1:`ICACHE_IDX_LSB];
  assign lu_tag = lookup_pc_i[`FETCH_ADDR_W-1:`ICACHE_TAG_LSB];

  // combinational hit, word picked by pc bit 2
  assign hit_o      = valid_q[lu_idx] && (tag_q[lu_idx] == lu_tag);
  assign hit_word_o = data_q[lu_idx][lu_ofs];

  // valid vector, flush beats a fill in the same cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (flush_i)
    begin
      valid_q <= '0;
    end
    else if (fill_we_i)
    begin
      valid_q[fill_i.idx] <= 1'b1;
    end
  end

  // whole line and tag written in one edge
  always_ff @(posedge clk)
  begin
    if (fill_we_i)
    begin
      data_q[fill_i.idx] <= fill_i.data;
      tag_q[fill_i.idx]  <= fill_i.tag;
    end
  end

  // the line being filled belongs to the pc the stage is holding,
  // so the retried lookup hits unless a flush got in between
  a_fill_matches_lookup: assert property (
    @(posedge clk) disable iff (rst)
    fill_we_i |-> (fill_i.idx == lu_idx) && (fill_i.tag == lu_tag)
  );

  a_fill_then_hit: assert property (
    @(posedge clk) disable iff (rst)
    fill_we_i && !flush_i |=> hit_o
  );

endmodule

// ==== hdl/icache_refill.sv ====
`include "fetch_defs.svh"

module icache_refill (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     miss_req_i,
  input  logic [`FETCH_ADDR_W-1:0] miss_addr_i,
  output logic                     fill_done_o,
  output fetch_pkg::line_fill_t    fill_o,
  output fetch_pkg::apb_req_t      apb_req_o,
  input  fetch_pkg::apb_rsp_t      apb_rsp_i
);

  import fetch_pkg::*;

  refill_state_e state_q;
  refill_beat_e  beat_q;

  // latched line address, low bits are implied zero
  logic [`FETCH_ADDR_W-1:`ICACHE_IDX_LSB] line_q;
  logic [`FETCH_DATA_W-1:0]               word0_q;
  logic [`FETCH_DATA_W-1:0]               word1_q;

  logic beat_done;

  // access phase ends on pready
  assign beat_done = (state_q == REFILL_ACCESS) && apb_rsp_i.pready;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= REFILL_IDLE;
      beat_q  <= BEAT_FIRST;
    end
    else
    begin
      case (state_q)
        REFILL_IDLE:
          if (miss_req_i)
          begin
            state_q <= REFILL_SETUP;
            beat_q  <= BEAT_FIRST;
          end
        REFILL_SETUP:
          state_q <= REFILL_ACCESS;
        REFILL_ACCESS:
          if (apb_rsp_i.pready)
          begin
            if (beat_q == BEAT_FIRST)
            begin
              beat_q  <= BEAT_SECOND;
              state_q <= REFILL_SETUP;
            end
            else
            begin
              state_q <= REFILL_WRITE;
            end
          end
        REFILL_WRITE:
          state_q <= REFILL_IDLE;
        default:
          state_q <= REFILL_IDLE;
      endcase
    end
  end

  // address and returned words
  always_ff @(posedge clk)
  begin
    if (state_q == REFILL_IDLE && miss_req_i)
    begin
      line_q <= miss_addr_i[`FETCH_ADDR_W-1:`ICACHE_IDX_LSB];
    end
    if (beat_done && beat_q == BEAT_FIRST)
    begin
      word0_q <= apb_rsp_i.prdata;
    end
    if (beat_done && beat_q == BEAT_SECOND)
    begin
      word1_q <= apb_rsp_i.prdata;
    end
  end

  // APB outputs straight from the state register
  assign apb_req_o.psel    = (state_q == REFILL_SETUP) || (state_q == REFILL_ACCESS);
  assign apb_req_o.penable = (state_q == REFILL_ACCESS);
  assign apb_req_o.paddr   = {line_q, (beat_q == BEAT_SECOND), 2'b00};

  // line write to the array
  assign fill_done_o = (state_q == REFILL_WRITE);
  assign fill_o.idx  = line_q[`ICACHE_TAG_LSB-1:`ICACHE_IDX_LSB];
  assign fill_o.tag  = line_q[`FETCH_ADDR_W-1:`ICACHE_TAG_LSB];
  assign fill_o.data = {word1_q, word0_q};

  a_penable_psel: assert property (
    @(posedge clk) disable iff (rst)
    apb_req_o.penable |-> apb_req_o.psel
  );

  // address held from setup until pready completes the transfer
  a_paddr_stable: assert property (
    @(posedge clk) disable iff (rst)
    apb_req_o.psel && !(apb_req_o.penable && apb_rsp_i.pready)
      |=> apb_req_o.psel && $stable(apb_req_o.paddr)
  );

endmodule

// ==== include/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// pc and bus widths
`define FETCH_ADDR_W 32
`define FETCH_DATA_W 32

// direct-mapped cache geometry
`define ICACHE_SETS 8
`define ICACHE_IDX_W 3
`define ICACHE_LINE_WORDS 2
`define ICACHE_OFS_W 1
`define ICACHE_TAG_W 26

// field positions inside the pc
`define ICACHE_OFS_LSB 2
`define ICACHE_IDX_LSB 3
`define ICACHE_TAG_LSB 6

// fence.i encoding, the only instruction the fetch block decodes
`define FENCE_I_INST 32'h0000100f

`endif

// ==== run.sh ====
#!/bin/sh
# build and run the fetch testbench, verdict taken from the simulation log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module fetch_tb \
  --Mdir obj_dir -o fetch_sim > build.log 2>&1 &&
./obj_dir/fetch_sim > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^Result: PASSED$" sim.log && echo "simulation ok" ||
{ echo "simulation reported errors, see sim.log"; exit 1; }

// ==== sim.f ====
+incdir+include
hdl/fetch_pkg.sv
hdl/icache_array.sv
hdl/icache_refill.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
verif/apb_mem_model.sv
verif/fetch_tb.sv

// ==== verif/apb_mem_model.sv ====
`include "fetch_defs.svh"

module apb_mem_model (
  input  logic                     clk,
  input  logic                     rst,
  input  fetch_pkg::apb_req_t      apb_req_i,
  output fetch_pkg::apb_rsp_t      apb_rsp_o,
  output int                       xfer_cnt_o,
  output logic [`FETCH_ADDR_W-1:0] last_addr_o,
  output logic [`FETCH_ADDR_W-1:0] prev_addr_o
);

  localparam logic [31:0] LFSR_SEED = 32'd84323;

  logic [31:0] lfsr_q;
  logic [31:0] lfsr_a;
  logic [31:0] lfsr_b;
  logic [1:0]  wait_q;

  // fibonacci form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [`FETCH_DATA_W-1:0] mem_word(
    input logic [`FETCH_ADDR_W-1:0] addr
  );
    if (addr == 32'h0000_0048)
      return `FENCE_I_INST;
    return addr ^ 32'h5A5A_0000;
  endfunction

  // one step per bit of the wait count
  assign lfsr_a = lfsr_step(lfsr_q);
  assign lfsr_b = lfsr_step(lfsr_a);

  // response changes on the falling edge only
  always @(negedge clk)
  begin
    if (rst)
    begin
      lfsr_q    <= LFSR_SEED;
      wait_q    <= 2'd0;
      apb_rsp_o <= '0;
    end
    else if (apb_req_i.psel && !apb_req_i.penable)
    begin
      // setup cycle draws 0 to 3 wait states
      lfsr_q           <= lfsr_b;
      wait_q           <= {lfsr_b[0], lfsr_a[0]};
      apb_rsp_o.pready <= 1'b0;
      apb_rsp_o.prdata <= mem_word(apb_req_i.paddr);
    end
    else if (apb_req_i.psel && apb_req_i.penable && wait_q != 2'd0)
      wait_q <= wait_q - 2'd1;
    else
      apb_rsp_o.pready <= apb_req_i.psel && apb_req_i.penable;
  end

  // completed transfers, seen on the edge where the master samples prdata
  always @(posedge clk)
  begin
    if (rst)
      xfer_cnt_o <= 0;
    else if (apb_req_i.psel && apb_req_i.penable && apb_rsp_o.pready)
    begin
      xfer_cnt_o  <= xfer_cnt_o + 1;
      prev_addr_o <= last_addr_o;
      last_addr_o <= apb_req_i.paddr;
    end
  end

endmodule

// ==== verif/fetch_tb.sv ====
`include "fetch_defs.svh"

module fetch_tb;

  import fetch_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int RST_CYCLES      = 4;
  localparam int NSTEPS          = 11;
  localparam int WATCHDOG_CYCLES = NSTEPS * 40 + RST_CYCLES;
  // cycles from acceptance to dn_valid_o
  localparam int HIT_CYCLES      = 1;
  localparam int MISS_MIN_CYCLES = 7;

  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] pc;
    int                       xfers;
    int                       hold;
  } step_t;

  // pc, APB transfers expected, cycles with dn_ready_i low
  step_t steps [NSTEPS] = '{
    '{32'h0000_0010, 2, 0},  // cold miss
    '{32'h0000_0014, 0, 0},
    '{32'h0000_0010, 0, 0},
    '{32'h0000_0050, 2, 0},  // same index as 0x10
    '{32'h0000_0010, 2, 3},
    '{32'h0000_0014, 0, 0},
    '{32'h0000_0048, 2, 2},  // fence.i word
    '{32'h0000_0014, 2, 0},
    '{32'h0000_004c, 2, 0},
    '{32'h0000_0020, 2, 4},
    '{32'h0000_0024, 0, 0}
  };

  logic clk = 1'b0;
  logic rst;
  logic up_valid;
  logic up_ready;
  fetch_req_t up_req;
  logic dn_valid;
  logic dn_ready;
  fetch_rsp_t dn_rsp;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  int xfer_cnt;
  logic [`FETCH_ADDR_W-1:0] last_addr;
  logic [`FETCH_ADDR_W-1:0] prev_addr;
  int errors;
  int checks;
  int step_errors;

  fetch_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .up_valid_i (up_valid),
    .up_ready_o (up_ready),
    .up_req_i   (up_req),
    .dn_valid_o (dn_valid),
    .dn_ready_i (dn_ready),
    .dn_rsp_o   (dn_rsp),
    .apb_req_o  (apb_req),
    .apb_rsp_i  (apb_rsp)
  );

  apb_mem_model i_mem (
    .clk         (clk),
    .rst         (rst),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .xfer_cnt_o  (xfer_cnt),
    .last_addr_o (last_addr),
    .prev_addr_o (prev_addr)
  );

  // memory contents as the fetch block should see them
  function automatic logic [`FETCH_DATA_W-1:0] expected_inst(input logic [31:0] addr);
    return (addr == 32'h0000_0048) ? `FENCE_I_INST : (addr ^ 32'h5A5A_0000);
  endfunction

  task automatic report_failure(input string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
    step_errors++;
  endtask

  task automatic check_rsp(input string name, input fetch_rsp_t got, input fetch_rsp_t exp);
    checks++;
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
      step_errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
      step_errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
      step_errors++;
    end
  endtask

  // one fetch from offer to delivery, entered and left on a falling edge
  task automatic run_step(input int n);
    fetch_rsp_t  exp;
    fetch_rsp_t  snap;
    logic [31:0] line;
    int          cnt0;
    int          cycles;
    step_errors = 0;
    exp.pc      = steps[n].pc;
    exp.inst    = expected_inst(steps[n].pc);
    line        = {steps[n].pc[31:3], 3'b000};
    cnt0        = xfer_cnt;
    if (!up_ready)
      report_failure("up_ready_o low while the fetch block should be idle");
    up_valid  = 1'b1;
    up_req.pc = steps[n].pc;
    @(negedge clk);
    up_valid = 1'b0;
    cycles   = 0;
    while (!dn_valid)
    begin
      @(negedge clk);
      cycles++;
    end
    if (steps[n].xfers == 0)
      check_count("hit latency", cycles, HIT_CYCLES);
    else if (cycles < MISS_MIN_CYCLES)
      report_failure($sformatf("miss delivered after only %0d cycles", cycles));
    snap = dn_rsp;
    check_rsp("dn_rsp_o", snap, exp);
    // back-pressure, the response must not move
    repeat (steps[n].hold)
    begin
      @(negedge clk);
      if (!dn_valid || up_ready)
        report_failure("handshake changed while dn_ready_i was low");
      check_rsp("dn_rsp_o held", dn_rsp, snap);
    end
    dn_ready = 1'b1;
    @(negedge clk);
    dn_ready = 1'b0;
    if (dn_valid)
      report_failure("dn_valid_o still high after the transfer");
    check_count("APB transfers", xfer_cnt - cnt0, steps[n].xfers);
    if (steps[n].xfers == 2)
    begin
      check_addr("first paddr", prev_addr, line);
      check_addr("second paddr", last_addr, line + 32'd4);
    end
    $display("step %0d pc %h: %0d cycles, %0d transfers, %s", n, steps[n].pc, cycles,
             xfer_cnt - cnt0, (step_errors == 0) ? "ok" : "errors");
  endtask

  initial
  begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: fetch sequence still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    rst      = 1'b1;
    up_valid = 1'b0;
    up_req   = '0;
    dn_ready = 1'b0;
    errors   = 0;
    checks   = 0;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    if (!up_ready || dn_valid || apb_req.psel || apb_req.penable)
      report_failure("outputs not in their idle state after reset");
    for (int n = 0; n < NSTEPS; n++)
      run_step(n);
    $display("steps %0d, checks %0d, errors %0d", NSTEPS, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule
